//--- rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data path and address width
`define RV_XLEN 32

// Register index width and register count
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// Address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

// Byte distance between sequential instructions
`define RV_PC_STEP 4

`endif

//--- rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  // Major opcodes of the base integer ISA
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b000_0011,
    OPC_STORE    = 7'b010_0011,
    OPC_BRANCH   = 7'b110_0011,
    OPC_JALR     = 7'b110_0111,
    OPC_MISC_MEM = 7'b000_1111,
    OPC_JAL      = 7'b110_1111,
    OPC_IMM      = 7'b001_0011,
    OPC_OP       = 7'b011_0011,
    OPC_SYSTEM   = 7'b111_0011,
    OPC_AUIPC    = 7'b001_0111,
    OPC_LUI      = 7'b011_0111
  } rv_opcode_e;

  // One view per encoding format
  typedef struct packed {
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    rv_opcode_e                opcode;
  } rv_insn_r_t;

  typedef struct packed {
    logic [11:0]               imm;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    rv_opcode_e                opcode;
  } rv_insn_i_t;

  typedef struct packed {
    logic [6:0]                imm_hi;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [4:0]                imm_lo;
    rv_opcode_e                opcode;
  } rv_insn_s_t;

  typedef struct packed {
    logic                      imm_12;
    logic [5:0]                imm_10_5;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [3:0]                imm_4_1;
    logic                      imm_11;
    rv_opcode_e                opcode;
  } rv_insn_b_t;

  typedef struct packed {
    logic [19:0]               imm;
    logic [`RV_REG_ADDR_W-1:0] rd;
    rv_opcode_e                opcode;
  } rv_insn_u_t;

  typedef struct packed {
    logic                      imm_20;
    logic [9:0]                imm_10_1;
    logic                      imm_11;
    logic [7:0]                imm_19_12;
    logic [`RV_REG_ADDR_W-1:0] rd;
    rv_opcode_e                opcode;
  } rv_insn_j_t;

  // Same 32-bit word, read through whichever format applies
  typedef union packed {
    rv_insn_r_t  r;
    rv_insn_i_t  i;
    rv_insn_s_t  s;
    rv_insn_b_t  b;
    rv_insn_u_t  u;
    rv_insn_j_t  j;
    logic [31:0] raw;
  } rv_insn_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } rv_alu_op_e;

  // Register write-back source
  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_PC4, WB_IMM
  } rv_wb_sel_e;

  typedef struct packed {
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    rv_alu_op_e                alu_op;
    logic                      src_b_imm;
    logic                      src_a_pc;
    logic                      reg_we;
    rv_wb_sel_e                wb_sel;
    logic                      is_branch;
    logic                      is_jal;
    logic                      is_jalr;
    logic                      is_load;
    logic                      is_store;
    logic                      is_halt;
  } rv_ctrl_t;

  // Data port request, one word per access
  typedef struct packed {
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN/8-1:0] be;
  } rv_dmem_req_t;

endpackage

//--- rv_fetch.sv
`include "rv_config.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::rv_ctrl_t    i_ctrl,
  input  logic [`RV_XLEN-1:0] i_imm,
  input  logic                i_branch_taken,
  input  logic [`RV_XLEN-1:0] i_alu_sum,
  output logic [`RV_XLEN-1:0] o_pc,
  output logic [`RV_XLEN-1:0] o_pc_plus4,
  output logic                o_halt
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_next;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_rel_target;
  logic [`RV_XLEN-1:0] jalr_target;
  logic                halt_q;

  assign pc_plus4      = pc_q + `RV_XLEN'(`RV_PC_STEP);
  // Shared by taken branches and JAL
  assign pc_rel_target = pc_q + i_imm;
  // JALR target drops bit 0 of rs1 + imm
  assign jalr_target   = {i_alu_sum[`RV_XLEN-1:1], 1'b0};

  always_comb begin
    pc_next = pc_plus4;
    if (i_ctrl.is_jalr) begin
      pc_next = jalr_target;
    end else if (i_ctrl.is_jal || (i_ctrl.is_branch && i_branch_taken)) begin
      pc_next = pc_rel_target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q   <= `RV_RESET_PC;
      halt_q <= 1'b0;
    end else begin
      // Halt is sticky until reset
      if (i_ctrl.is_halt) begin
        halt_q <= 1'b1;
      end
      // ECALL leaves the PC on its own address
      if (!halt_q && !i_ctrl.is_halt) begin
        pc_q <= pc_next;
      end
    end
  end

  assign o_pc       = pc_q;
  assign o_pc_plus4 = pc_plus4;
  assign o_halt     = halt_q;

endmodule

//--- rv_decoder.sv
`include "rv_config.svh"

module rv_decoder (
  input  rv_pkg::rv_insn_u    i_insn,
  output rv_pkg::rv_ctrl_t    o_ctrl,
  output logic [`RV_XLEN-1:0] o_imm
);

  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;
  localparam logic [2:0] FUNCT3_WORD = 3'b010;

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                is_alt;

  // Integer op from funct3, alt selects SUB or SRA
  function automatic rv_pkg::rv_alu_op_e int_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  return rv_pkg::ALU_SLL;
      3'b010:  return rv_pkg::ALU_SLT;
      3'b011:  return rv_pkg::ALU_SLTU;
      3'b100:  return rv_pkg::ALU_XOR;
      3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  function automatic rv_pkg::rv_alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return rv_pkg::ALU_EQ;
      3'b001:  return rv_pkg::ALU_NE;
      3'b100:  return rv_pkg::ALU_LT;
      3'b101:  return rv_pkg::ALU_GE;
      3'b110:  return rv_pkg::ALU_LTU;
      default: return rv_pkg::ALU_GEU;
    endcase
  endfunction

  assign funct3 = i_insn.i.funct3;
  assign funct7 = i_insn.r.funct7;
  assign is_alt = (funct7 == FUNCT7_ALT);

  // Sign-extended immediates of every format
  assign imm_i = {{(`RV_XLEN-12){i_insn.i.imm[11]}}, i_insn.i.imm};
  assign imm_s = {{(`RV_XLEN-12){i_insn.s.imm_hi[6]}}, i_insn.s.imm_hi, i_insn.s.imm_lo};
  assign imm_b = {{(`RV_XLEN-13){i_insn.b.imm_12}}, i_insn.b.imm_12, i_insn.b.imm_11,
                  i_insn.b.imm_10_5, i_insn.b.imm_4_1, 1'b0};
  assign imm_u = {i_insn.u.imm, 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_insn.j.imm_20}}, i_insn.j.imm_20, i_insn.j.imm_19_12,
                  i_insn.j.imm_11, i_insn.j.imm_10_1, 1'b0};

  always_comb begin
    // Default is a no-op that only advances the PC
    o_ctrl        = '0;
    o_ctrl.rd     = i_insn.r.rd;
    o_ctrl.rs1    = i_insn.r.rs1;
    o_ctrl.rs2    = i_insn.r.rs2;
    o_ctrl.alu_op = rv_pkg::ALU_ADD;
    o_ctrl.wb_sel = rv_pkg::WB_ALU;
    o_imm         = '0;
    case (i_insn.r.opcode)
      rv_pkg::OPC_LUI: begin
        o_imm         = imm_u;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.wb_sel = rv_pkg::WB_IMM;
      end
      rv_pkg::OPC_AUIPC: begin
        o_imm            = imm_u;
        o_ctrl.src_a_pc  = 1'b1;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.reg_we    = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        o_imm         = imm_j;
        o_ctrl.is_jal = 1'b1;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.wb_sel = rv_pkg::WB_PC4;
      end
      rv_pkg::OPC_JALR: begin
        o_imm = imm_i;
        if (funct3 == 3'b000) begin
          o_ctrl.src_b_imm = 1'b1;
          o_ctrl.is_jalr   = 1'b1;
          o_ctrl.reg_we    = 1'b1;
          o_ctrl.wb_sel    = rv_pkg::WB_PC4;
        end
      end
      rv_pkg::OPC_BRANCH: begin
        o_imm = imm_b;
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          o_ctrl.is_branch = 1'b1;
          o_ctrl.alu_op    = branch_op(funct3);
        end
      end
      rv_pkg::OPC_LOAD: begin
        o_imm = imm_i;
        // Word loads only, sub-word forms fall through as no-ops
        if (funct3 == FUNCT3_WORD) begin
          o_ctrl.src_b_imm = 1'b1;
          o_ctrl.is_load   = 1'b1;
          o_ctrl.reg_we    = 1'b1;
          o_ctrl.wb_sel    = rv_pkg::WB_LOAD;
        end
      end
      rv_pkg::OPC_STORE: begin
        o_imm = imm_s;
        if (funct3 == FUNCT3_WORD) begin
          o_ctrl.src_b_imm = 1'b1;
          o_ctrl.is_store  = 1'b1;
        end
      end
      rv_pkg::OPC_IMM: begin
        o_imm            = imm_i;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.alu_op    = int_op(funct3, funct3 == 3'b101 && is_alt);
        // Shift immediates carry a funct7 in the upper bits
        if (funct3 == 3'b001) begin
          o_ctrl.reg_we = (funct7 == FUNCT7_BASE);
        end else if (funct3 == 3'b101) begin
          o_ctrl.reg_we = (funct7 == FUNCT7_BASE) || is_alt;
        end else begin
          o_ctrl.reg_we = 1'b1;
        end
      end
      rv_pkg::OPC_OP: begin
        o_ctrl.alu_op = int_op(funct3, is_alt);
        // M extension (funct7 = 1) decodes as a no-op
        o_ctrl.reg_we = (funct7 == FUNCT7_BASE) ||
                        (is_alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_pkg::OPC_SYSTEM: begin
        o_ctrl.is_halt = (i_insn.raw[31:7] == '0);
      end
      rv_pkg::OPC_MISC_MEM: begin
        // FENCE has nothing to order in a single-cycle core
      end
      default: begin
      end
    endcase
  end

endmodule

//--- rv_regfile.sv
`include "rv_config.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] i_rs1,
  input  logic [`RV_REG_ADDR_W-1:0] i_rs2,
  input  logic [`RV_REG_ADDR_W-1:0] i_rd,
  input  logic                      i_we,
  input  logic [`RV_XLEN-1:0]       i_rd_data,
  output logic [`RV_XLEN-1:0]       o_rs1_data,
  output logic [`RV_XLEN-1:0]       o_rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // Asynchronous reads, x0 reads as zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- rv_alu.sv
`include "rv_config.svh"

module rv_alu (
  input  rv_pkg::rv_alu_op_e  i_op,
  input  logic [`RV_XLEN-1:0] i_a,
  input  logic [`RV_XLEN-1:0] i_b,
  output logic [`RV_XLEN-1:0] o_result,
  output logic                o_branch_taken
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] diff;
  logic [SHAMT_W-1:0]  shamt;
  logic                eq;
  logic                lt_s;
  logic                lt_u;

  assign sum   = i_a + i_b;
  assign diff  = i_a - i_b;
  assign shamt = i_b[SHAMT_W-1:0];
  assign eq    = (i_a == i_b);
  assign lt_s  = ($signed(i_a) < $signed(i_b));
  assign lt_u  = (i_a < i_b);

  always_comb begin
    // Compare ops leave the adder output on the result
    o_result       = sum;
    o_branch_taken = 1'b0;
    case (i_op)
      rv_pkg::ALU_ADD:  o_result = sum;
      rv_pkg::ALU_SUB:  o_result = diff;
      rv_pkg::ALU_SLL:  o_result = i_a << shamt;
      rv_pkg::ALU_SLT:  o_result = `RV_XLEN'(lt_s);
      rv_pkg::ALU_SLTU: o_result = `RV_XLEN'(lt_u);
      rv_pkg::ALU_XOR:  o_result = i_a ^ i_b;
      rv_pkg::ALU_SRL:  o_result = i_a >> shamt;
      rv_pkg::ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
      rv_pkg::ALU_OR:   o_result = i_a | i_b;
      rv_pkg::ALU_AND:  o_result = i_a & i_b;
      rv_pkg::ALU_EQ:   o_branch_taken = eq;
      rv_pkg::ALU_NE:   o_branch_taken = !eq;
      rv_pkg::ALU_LT:   o_branch_taken = lt_s;
      rv_pkg::ALU_GE:   o_branch_taken = !lt_s;
      rv_pkg::ALU_LTU:  o_branch_taken = lt_u;
      rv_pkg::ALU_GEU:  o_branch_taken = !lt_u;
      default: begin
      end
    endcase
  end

endmodule

//--- rv_writeback.sv
`include "rv_config.svh"

module rv_writeback (
  input  rv_pkg::rv_ctrl_t     i_ctrl,
  input  logic [`RV_XLEN-1:0]  i_alu_result,
  input  logic [`RV_XLEN-1:0]  i_rs2_data,
  input  logic [`RV_XLEN-1:0]  i_pc_plus4,
  input  logic [`RV_XLEN-1:0]  i_imm,
  input  logic [`RV_XLEN-1:0]  i_load_data,
  output rv_pkg::rv_dmem_req_t o_dmem_req,
  output logic                 o_rd_we,
  output logic [`RV_XLEN-1:0]  o_rd_data
);

  logic aligned;

  // Only whole-word accesses exist
  assign aligned = (i_alu_result[1:0] == 2'b00);

  always_comb begin
    o_dmem_req.addr  = {i_alu_result[`RV_XLEN-1:2], 2'b00};
    o_dmem_req.wdata = i_rs2_data;
    // Store strobe, dropped for a misaligned address
    o_dmem_req.be    = (i_ctrl.is_store && aligned) ? '1 : '0;
  end

  always_comb begin
    case (i_ctrl.wb_sel)
      rv_pkg::WB_ALU:  o_rd_data = i_alu_result;
      rv_pkg::WB_LOAD: o_rd_data = i_load_data;
      rv_pkg::WB_PC4:  o_rd_data = i_pc_plus4;
      rv_pkg::WB_IMM:  o_rd_data = i_imm;
      default:         o_rd_data = i_alu_result;
    endcase
  end

  // Misaligned load leaves rd untouched
  assign o_rd_we = i_ctrl.reg_we && !(i_ctrl.is_load && !aligned);

endmodule

//--- rv_core.sv
`include "rv_config.svh"

module rv_core (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`RV_XLEN-1:0]  i_insn,
  input  logic [`RV_XLEN-1:0]  i_load_data,
  output logic [`RV_XLEN-1:0]  o_pc,
  output rv_pkg::rv_dmem_req_t o_dmem_req,
  output logic                 o_halt
);

  rv_pkg::rv_ctrl_t    ctrl;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] rd_data;
  logic                branch_taken;
  logic                rd_we;

  // Operand muxes, PC for AUIPC and immediate for I/S/U forms
  assign alu_a = ctrl.src_a_pc ? o_pc : rs1_data;
  assign alu_b = ctrl.src_b_imm ? imm : rs2_data;

  rv_fetch rv_fetch_inst (
    .clk            (clk),
    .rst            (rst),
    .i_ctrl         (ctrl),
    .i_imm          (imm),
    .i_branch_taken (branch_taken),
    .i_alu_sum      (alu_result),
    .o_pc           (o_pc),
    .o_pc_plus4     (pc_plus4),
    .o_halt         (o_halt)
  );

  rv_decoder rv_decoder_inst (
    .i_insn (i_insn),
    .o_ctrl (ctrl),
    .o_imm  (imm)
  );

  rv_regfile rv_regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (ctrl.rs1),
    .i_rs2      (ctrl.rs2),
    .i_rd       (ctrl.rd),
    .i_we       (rd_we),
    .i_rd_data  (rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_alu rv_alu_inst (
    .i_op           (ctrl.alu_op),
    .i_a            (alu_a),
    .i_b            (alu_b),
    .o_result       (alu_result),
    .o_branch_taken (branch_taken)
  );

  rv_writeback rv_writeback_inst (
    .i_ctrl       (ctrl),
    .i_alu_result (alu_result),
    .i_rs2_data   (rs2_data),
    .i_pc_plus4   (pc_plus4),
    .i_imm        (imm),
    .i_load_data  (i_load_data),
    .o_dmem_req   (o_dmem_req),
    .o_rd_we      (rd_we),
    .o_rd_data    (rd_data)
  );

endmodule

//--- tb_rv_core.sv
`include "rv_config.svh"

module tb_rv_core;

  localparam logic [6:0] OPC_IMM   = 7'h13;
  localparam logic [6:0] OPC_OP    = 7'h33;
  localparam logic [6:0] OPC_LUI   = 7'h37;
  localparam logic [6:0] OPC_AUIPC = 7'h17;
  localparam logic [6:0] OPC_JALR  = 7'h67;
  localparam logic [6:0] OPC_LOAD  = 7'h03;
  localparam logic [31:0] ECALL    = 32'h0000_0073;
  // Data region starts at byte 0x200 (word 128)
  localparam int DATA_WORD = 128;

  logic                 clk;
  logic                 rst;
  logic [31:0]          insn;
  logic [31:0]          load_data;
  logic [31:0]          pc;
  rv_pkg::rv_dmem_req_t dmem_req;
  logic                 halt;

  logic [31:0] mem [0:255];
  logic [31:0] prog [$];
  logic [31:0] expect_q [$];
  logic [31:0] lfsr_state = 32'h28b7;

  rv_core rv_core_inst (
    .clk         (clk),
    .rst         (rst),
    .i_insn      (insn),
    .i_load_data (load_data),
    .o_pc        (pc),
    .o_dmem_req  (dmem_req),
    .o_halt      (halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Memory model with combinational reads and byte-enabled writes
  assign insn      = mem[pc[9:2]];
  assign load_data = mem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_req.be[b]) begin
        mem[dmem_req.addr[9:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
      end
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] fill_word(input int unsigned addr);
    return 32'hfeed_0000 | addr;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // RV32I integer results where alt picks SUB and SRA
  function automatic logic [31:0] int_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // Every program keeps the data base address in x31
  task automatic start_program();
    prog.delete();
    expect_q.delete();
    emit(i_type(12'h200, 5'd0, 3'd0, 5'd31, OPC_IMM));
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    emit(u_type(upper[19:0], rd, OPC_LUI));
    emit(i_type(value[11:0], rd, 3'd0, rd, OPC_IMM));
  endtask

  // Runs insn and then stores rd to the next result word
  task automatic store_result(input logic [31:0] word, input logic [4:0] rd,
                              input logic [31:0] expected);
    emit(word);
    emit(s_type(12'(4 * expect_q.size()), rd, 5'd31));
    expect_q.push_back(expected);
  endtask

  task automatic run_program(input string name);
    int cycles;
    int limit;
    emit(ECALL);
    limit = 4 * prog.size() + 50;
    rst = 1'b1;
    @(posedge clk);
    #1;
    for (int a = 0; a < 256; a++) begin
      mem[a] = (a < prog.size()) ? prog[a] : fill_word(a);
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    cycles = 0;
    while (!halt) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > limit) begin
        $display("timeout: %s did not halt within %0d cycles", name, limit);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
      end
    end
  endtask

  task automatic compare_data_words(input string name);
    for (int k = 0; k < expect_q.size(); k++) begin
      check($sformatf("%s word %0d", name, k), expect_q[k], mem[DATA_WORD + k]);
    end
  endtask

  task automatic reg_imm_ops();
    logic [31:0] a;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    start_program();
    // Negative operand so SRAI and SRLI differ
    a = rand_bits(32) | 32'h8000_0000;
    load_const(5'd1, a);
    // SRAI sits at k = 8 while the rest follow funct3
    for (int k = 0; k < 9; k++) begin
      f3  = (k < 8) ? 3'(k) : 3'd5;
      alt = (k == 8);
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {alt ? 7'h20 : 7'h00, 5'(rand_bits(5)) | 5'd1};
      end else begin
        imm = 12'(rand_bits(12));
      end
      store_result(i_type(imm, 5'd1, f3, 5'd5, OPC_IMM), 5'd5,
                   int_model(f3, alt, a, {{20{imm[11]}}, imm}));
    end
    run_program("reg_imm");
    compare_data_words("reg_imm");
  endtask

  task automatic reg_reg_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic        alt;
    start_program();
    a = rand_bits(32) | 32'h8000_0000;
    // Positive with a nonzero shift amount
    b = rand_bits(31) | 32'h1;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      store_result(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd5), 5'd5,
                   int_model(f3, alt, a, b));
    end
    store_result(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0), 5'd0, 32'h0);
    run_program("reg_reg");
    compare_data_words("reg_reg");
  endtask

  task automatic upper_and_jumps();
    logic [19:0] u;
    logic [31:0] jal_pc;
    logic [31:0] jalr_pc;
    logic [31:0] target;
    start_program();
    u = 20'(rand_bits(20));
    store_result(u_type(u, 5'd1, OPC_AUIPC), 5'd1, 4 * prog.size() + {u, 12'b0});
    jal_pc = 4 * prog.size();
    emit(j_type(21'd8, 5'd2));
    emit(s_type(12'd4, 5'd31, 5'd31));
    expect_q.push_back(fill_word(DATA_WORD + 1));
    emit(s_type(12'd8, 5'd2, 5'd31));
    expect_q.push_back(jal_pc + 4);
    // Odd target checks that JALR clears bit 0
    jalr_pc = 4 * prog.size() + 4;
    target  = jalr_pc + 12;
    emit(i_type(12'(target + 1), 5'd0, 3'd0, 5'd3, OPC_IMM));
    emit(i_type(12'd0, 5'd3, 3'd0, 5'd4, OPC_JALR));
    emit(s_type(12'd12, 5'd31, 5'd31));
    expect_q.push_back(fill_word(DATA_WORD + 3));
    emit(s_type(12'd16, 5'd31, 5'd31));
    expect_q.push_back(fill_word(DATA_WORD + 4));
    emit(s_type(12'd20, 5'd4, 5'd31));
    expect_q.push_back(jalr_pc + 4);
    run_program("jumps");
    compare_data_words("jumps");
  endtask

  task automatic branch_outcomes();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        taken;
    start_program();
    // Negative against positive splits signed and unsigned compares
    a = rand_bits(32) | 32'h8000_0000;
    b = rand_bits(31);
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 12; k++) begin
      f3  = (k < 4) ? 3'(k / 2) : 3'(k / 2 + 2);
      rs1 = (f3 < 3'd2 || k[0] == 1'b0) ? 5'd1 : 5'd2;
      rs2 = (f3 < 3'd2 && k[0] == 1'b0) ? 5'd1 : ((rs1 == 5'd1) ? 5'd2 : 5'd1);
      taken = branch_model(f3, (rs1 == 5'd1) ? a : b, (rs2 == 5'd1) ? a : b);
      emit(b_type(13'd8, rs2, rs1, f3));
      emit(s_type(12'(4 * expect_q.size()), 5'd31, 5'd31));
      expect_q.push_back(taken ? fill_word(DATA_WORD + expect_q.size()) : 32'h200);
    end
    run_program("branches");
    compare_data_words("branches");
  endtask

  task automatic load_store_halt();
    logic [31:0] a;
    logic [31:0] ecall_pc;
    start_program();
    a = rand_bits(32);
    load_const(5'd1, a);
    emit(s_type(12'd0, 5'd1, 5'd31));
    expect_q.push_back(a);
    emit(i_type(12'd0, 5'd31, 3'b010, 5'd2, OPC_LOAD));
    emit(s_type(12'd4, 5'd2, 5'd31));
    expect_q.push_back(a);
    // Misaligned store to 0x20a must leave both nearby words alone
    emit(s_type(12'd10, 5'd1, 5'd31));
    expect_q.push_back(fill_word(DATA_WORD + 2));
    expect_q.push_back(fill_word(DATA_WORD + 3));
    ecall_pc = 4 * prog.size();
    run_program("load_halt");
    compare_data_words("load_halt");
    repeat (5) begin
      @(posedge clk);
      #1;
      check("halt held", 32'h1, {31'b0, halt});
      check("pc held at ecall", ecall_pc, pc);
    end
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check("halt after reset", 32'h0, {31'b0, halt});
    check("pc after reset", `RV_RESET_PC, pc);
  endtask

  initial begin
    rst = 1'b1;
    @(posedge clk);
    #1;
    reg_imm_ops();
    reg_reg_ops();
    upper_and_jumps();
    branch_outcomes();
    load_store_halt();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_writeback.sv
rv_core.sv
tb_rv_core.sv
